// ==== logic/tdma_defines.svh ====
`ifndef TDMA_DEFINES_SVH
`define TDMA_DEFINES_SVH

// fine pulses per second minus one
`define TDMA_PULSE2_WRAP 32'd999999

// fine pulses per slot of one millisecond
`define TDMA_SLOT_PULSES 1000

// slots per frame
`define TDMA_FRAME_SLOTS 100

// broadcast-slot code for "no slot owned"
`define TDMA_NO_SLOT 16'hffff

// flops in each GPS pulse synchroniser chain
`define TDMA_SYNC_STAGES 2

// send-buffer words per ping payload
`define TDMA_PKT_WORDS 4

`endif

// ==== logic/tdma_pkg.sv ====
`default_nettype none

package tdma_pkg;

    typedef logic [31:0] gps_count_t;
    typedef logic [31:0] utc_sec_t;
    typedef logic [15:0] slot_index_t;
    typedef logic [9:0]  slot_tick_t;
    typedef logic [31:0] ping_seq_t;
    typedef logic [31:0] pkt_word_t;
    typedef logic [8:0]  sendbuf_addr_t;

    // payload kind sent as the first word of every payload
    typedef enum logic [5:0] {
        KIND_PING     = 6'd1,
        KIND_ACK_PING = 6'd2
    } pkt_kind_e;

    typedef enum logic [2:0] {
        PING_IDLE,
        PING_WAIT_TXEN,
        PING_PROCESS_ACK,
        PING_WR_KIND,
        PING_WR_SEQ,
        PING_WR_SEC,
        PING_WR_CNT2,
        PING_DONE
    } ping_state_e;

    typedef struct packed {
        gps_count_t pulse1_count;
        gps_count_t pulse2_count;
        utc_sec_t   utc_sec;
    } gps_time_t;

    typedef struct packed {
        slot_index_t slot_index;
        slot_tick_t  slot_tick;
    } slot_status_t;

    // fields carried in a ping or its acknowledgment
    typedef struct packed {
        ping_seq_t  seq;
        utc_sec_t   sec;
        gps_count_t counter2;
    } ping_fields_t;

    typedef struct packed {
        ping_seq_t  res_seq;
        gps_count_t res_delta_t;
    } ping_report_t;

    typedef struct packed {
        logic          we;
        sendbuf_addr_t addr;
        pkt_word_t     data;
    } sendbuf_wr_t;

endpackage

`default_nettype wire

// ==== logic/gps_pulse_sync.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "tdma_defines.svh"

module gps_pulse_sync (
    input  wire  clk,
    input  wire  reset_n,
    input  wire  gps_timepulse_1,
    input  wire  gps_timepulse_2,
    output logic pulse1_edge,
    output logic pulse2_edge
);

    // bit 0 is time pulse 1, bit 1 is time pulse 2
    logic [1:0] pins;
    logic [1:0] sync_q [`TDMA_SYNC_STAGES];
    logic [1:0] level_d;
    logic [1:0] edge_q;

    assign pins = {gps_timepulse_2, gps_timepulse_1};

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            sync_q  <= '{default: '0};
            level_d <= '0;
            edge_q  <= '0;
        end else begin
            sync_q[0] <= pins;
            for (int i = 1; i < `TDMA_SYNC_STAGES; i++) begin
                sync_q[i] <= sync_q[i-1];
            end
            level_d <= sync_q[`TDMA_SYNC_STAGES-1];
            // registered strobe high for one cycle per rising edge
            edge_q  <= sync_q[`TDMA_SYNC_STAGES-1] & ~level_d;
        end
    end

    assign pulse1_edge = edge_q[0];
    assign pulse2_edge = edge_q[1];

endmodule

`default_nettype wire

// ==== logic/gps_time_base.sv ====
`timescale 1ns/1ps
`default_nettype none

module gps_time_base (
    input  wire                  clk,
    input  wire                  reset_n,
    input  wire                  pulse1_edge,
    input  wire                  pulse2_edge,
    input  wire tdma_pkg::utc_sec_t utc_sec_in,
    output tdma_pkg::gps_time_t  gps_time,
    output logic                 pulse2_restart
);

    // second count seen by the last fine pulse
    tdma_pkg::gps_count_t sec_copy;

    // first fine pulse of a new second
    assign pulse2_restart = pulse2_edge && (gps_time.pulse1_count != sec_copy);

    ////////////////////////////////////////////////////////////////////////////
    // second counter and UTC latch
    ////////////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            gps_time.pulse1_count <= '0;
            gps_time.utc_sec      <= '0;
        end else if (pulse1_edge) begin
            gps_time.pulse1_count <= gps_time.pulse1_count + 32'd1;
            gps_time.utc_sec      <= utc_sec_in;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // fine pulse counter restarting once per second
    ////////////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            gps_time.pulse2_count <= '0;
            sec_copy              <= '0;
        end else if (pulse2_restart) begin
            gps_time.pulse2_count <= '0;
            sec_copy              <= gps_time.pulse1_count;
        end else if (pulse2_edge) begin
            gps_time.pulse2_count <= gps_time.pulse2_count + 32'd1;
        end
    end

endmodule

`default_nettype wire

// ==== logic/slot_scheduler.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "tdma_defines.svh"

module slot_scheduler (
    input  wire                        clk,
    input  wire                        reset_n,
    input  wire                        pulse2_edge,
    input  wire                        pulse2_restart,
    input  wire                        tdma_function_enable,
    input  wire tdma_pkg::slot_index_t bch_user_pointer,
    output tdma_pkg::slot_status_t     slot_status,
    output logic                       tx_enable
);

    localparam tdma_pkg::slot_tick_t  tick_last  =
        tdma_pkg::slot_tick_t'(`TDMA_SLOT_PULSES - 1);
    localparam tdma_pkg::slot_index_t index_last =
        tdma_pkg::slot_index_t'(`TDMA_FRAME_SLOTS - 1);

    tdma_pkg::slot_index_t bch_ptr;
    logic                  bch_owned;

    ////////////////////////////////////////////////////////////////////////////
    // slot tick and slot index
    ////////////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            slot_status <= '0;
        end else if (pulse2_restart) begin
            slot_status <= '0;
        end else if (pulse2_edge) begin
            if (slot_status.slot_tick == tick_last) begin
                slot_status.slot_tick <= '0;
                if (slot_status.slot_index == index_last) begin
                    slot_status.slot_index <= '0;
                end else begin
                    slot_status.slot_index <= slot_status.slot_index + 16'd1;
                end
            end else begin
                slot_status.slot_tick <= slot_status.slot_tick + 10'd1;
            end
        end
    end

    // broadcast slot pointer and whether we own one
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            bch_ptr   <= `TDMA_NO_SLOT;
            bch_owned <= 1'b0;
        end else begin
            bch_ptr   <= bch_user_pointer;
            bch_owned <= (bch_user_pointer != `TDMA_NO_SLOT);
        end
    end

    // gate stays open while TDMA is off
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            tx_enable <= 1'b1;
        end else if (!tdma_function_enable) begin
            tx_enable <= 1'b1;
        end else begin
            tx_enable <= bch_owned && (bch_ptr == slot_status.slot_index);
        end
    end

endmodule

`default_nettype wire

// ==== logic/ping_engine.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "tdma_defines.svh"

module ping_engine (
    input  wire                         clk,
    input  wire                         reset_n,
    input  wire tdma_pkg::gps_time_t    gps_time,
    input  wire                         tx_enable,
    input  wire                         start_ping,
    input  wire                         open_loop,
    input  wire                         recv_ping,
    input  wire                         recv_ack_ping,
    input  wire tdma_pkg::ping_fields_t recv_fields,
    output tdma_pkg::sendbuf_wr_t       sendbuf,
    output tdma_pkg::ping_report_t      ping_report,
    output logic                        send_ping
);

    tdma_pkg::ping_state_e  state;
    tdma_pkg::pkt_kind_e    pkt_kind;
    tdma_pkg::ping_fields_t pkt_fields;
    tdma_pkg::gps_count_t   ack_delta;

    // round trip in fine pulses across a second boundary if needed
    assign ack_delta = (pkt_fields.sec == gps_time.utc_sec) ?
                       (gps_time.pulse2_count - pkt_fields.counter2) :
                       (gps_time.pulse2_count + `TDMA_PULSE2_WRAP - pkt_fields.counter2);

    ////////////////////////////////////////////////////////////////////////////
    // state machine and ping report
    ////////////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state       <= tdma_pkg::PING_IDLE;
            ping_report <= '0;
        end else begin
            case (state)
                tdma_pkg::PING_IDLE: begin
                    if (start_ping) begin
                        state <= tdma_pkg::PING_WAIT_TXEN;
                    end else if (recv_ping) begin
                        state <= tdma_pkg::PING_WR_KIND;
                    end else if (recv_ack_ping) begin
                        state <= tdma_pkg::PING_PROCESS_ACK;
                    end
                end
                tdma_pkg::PING_WAIT_TXEN: begin
                    if (tx_enable) begin
                        state <= tdma_pkg::PING_WR_KIND;
                    end
                end
                tdma_pkg::PING_PROCESS_ACK: begin
                    ping_report.res_seq     <= pkt_fields.seq;
                    ping_report.res_delta_t <= ack_delta;
                    state <= open_loop ? tdma_pkg::PING_WR_KIND : tdma_pkg::PING_IDLE;
                end
                tdma_pkg::PING_WR_KIND: state <= tdma_pkg::PING_WR_SEQ;
                tdma_pkg::PING_WR_SEQ:  state <= tdma_pkg::PING_WR_SEC;
                tdma_pkg::PING_WR_SEC:  state <= tdma_pkg::PING_WR_CNT2;
                tdma_pkg::PING_WR_CNT2: state <= tdma_pkg::PING_DONE;
                default:                state <= tdma_pkg::PING_IDLE;
            endcase
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // payload fields
    ////////////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        case (state)
            tdma_pkg::PING_IDLE: begin
                if (start_ping) begin
                    pkt_kind <= tdma_pkg::KIND_PING;
                end else if (recv_ping) begin
                    // reply echoes the received fields
                    pkt_kind   <= tdma_pkg::KIND_ACK_PING;
                    pkt_fields <= recv_fields;
                end else if (recv_ack_ping) begin
                    pkt_fields <= recv_fields;
                end
            end
            tdma_pkg::PING_WAIT_TXEN: begin
                if (tx_enable) begin
                    pkt_fields.seq      <= 32'd1;
                    pkt_fields.sec      <= gps_time.utc_sec;
                    pkt_fields.counter2 <= gps_time.pulse2_count;
                end
            end
            tdma_pkg::PING_PROCESS_ACK: begin
                if (open_loop) begin
                    pkt_kind            <= tdma_pkg::KIND_PING;
                    pkt_fields.seq      <= pkt_fields.seq + 32'd1;
                    pkt_fields.sec      <= gps_time.utc_sec;
                    pkt_fields.counter2 <= gps_time.pulse2_count;
                end
            end
            default: begin
            end
        endcase
    end

    // send-buffer port with one word per write state
    always_comb begin
        sendbuf.we   = 1'b0;
        sendbuf.addr = '0;
        sendbuf.data = '0;
        case (state)
            tdma_pkg::PING_WR_KIND: begin
                sendbuf.we   = 1'b1;
                sendbuf.addr = 9'd0;
                sendbuf.data = {26'd0, pkt_kind};
            end
            tdma_pkg::PING_WR_SEQ: begin
                sendbuf.we   = 1'b1;
                sendbuf.addr = 9'd1;
                sendbuf.data = pkt_fields.seq;
            end
            tdma_pkg::PING_WR_SEC: begin
                sendbuf.we   = 1'b1;
                sendbuf.addr = 9'd2;
                sendbuf.data = pkt_fields.sec;
            end
            tdma_pkg::PING_WR_CNT2: begin
                sendbuf.we   = 1'b1;
                sendbuf.addr = 9'd3;
                sendbuf.data = pkt_fields.counter2;
            end
            default: begin
            end
        endcase
    end

    assign send_ping = (state == tdma_pkg::PING_DONE);

endmodule

`default_nettype wire

// ==== logic/tx_launcher.sv ====
`timescale 1ns/1ps
`default_nettype none

module tx_launcher (
    input  wire  clk,
    input  wire  reset_n,
    input  wire  send_ping,
    input  wire  test_sendpkt,
    input  wire  tx_enable,
    input  wire  tx_ack,
    output logic tx_req
);

    logic [4:0] pend_cnt;
    logic [4:0] served_cnt;
    // request dropped and waiting for tx_ack to fall
    logic       ack_wait;

    // both sources may pulse in the same cycle
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            pend_cnt <= '0;
        end else begin
            pend_cnt <= pend_cnt + {4'd0, send_ping} + {4'd0, test_sendpkt};
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // four-phase requester
    ////////////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            tx_req     <= 1'b0;
            ack_wait   <= 1'b0;
            served_cnt <= '0;
        end else if (tx_req) begin
            if (tx_ack) begin
                tx_req   <= 1'b0;
                ack_wait <= 1'b1;
            end
        end else if (ack_wait) begin
            if (!tx_ack) begin
                ack_wait   <= 1'b0;
                served_cnt <= served_cnt + 5'd1;
            end
        end else if (tx_enable && !tx_ack && (pend_cnt != served_cnt)) begin
            tx_req <= 1'b1;
        end
    end

endmodule

`default_nettype wire

// ==== logic/tdma_control.sv ====
`timescale 1ns/1ps
`default_nettype none

module tdma_control (
    input  wire                         clk,
    input  wire                         reset_n,
    input  wire                         gps_timepulse_1,
    input  wire                         gps_timepulse_2,
    input  wire tdma_pkg::utc_sec_t     utc_sec_in,
    input  wire                         tdma_function_enable,
    input  wire tdma_pkg::slot_index_t  bch_user_pointer,
    input  wire                         start_ping,
    input  wire                         open_loop,
    input  wire                         recv_ping,
    input  wire                         recv_ack_ping,
    input  wire tdma_pkg::ping_fields_t recv_fields,
    input  wire                         test_sendpkt,
    input  wire                         tx_ack,
    output tdma_pkg::gps_time_t         gps_time,
    output tdma_pkg::slot_status_t      slot_status,
    output logic                        tx_enable,
    output tdma_pkg::sendbuf_wr_t       sendbuf,
    output tdma_pkg::ping_report_t      ping_report,
    output logic                        tx_req
);

    logic pulse1_edge;
    logic pulse2_edge;
    logic pulse2_restart;
    logic send_ping;

    gps_pulse_sync i_gps_pulse_sync (
        .clk             (clk),
        .reset_n         (reset_n),
        .gps_timepulse_1 (gps_timepulse_1),
        .gps_timepulse_2 (gps_timepulse_2),
        .pulse1_edge     (pulse1_edge),
        .pulse2_edge     (pulse2_edge)
    );

    gps_time_base i_gps_time_base (
        .clk            (clk),
        .reset_n        (reset_n),
        .pulse1_edge    (pulse1_edge),
        .pulse2_edge    (pulse2_edge),
        .utc_sec_in     (utc_sec_in),
        .gps_time       (gps_time),
        .pulse2_restart (pulse2_restart)
    );

    slot_scheduler i_slot_scheduler (
        .clk                  (clk),
        .reset_n              (reset_n),
        .pulse2_edge          (pulse2_edge),
        .pulse2_restart       (pulse2_restart),
        .tdma_function_enable (tdma_function_enable),
        .bch_user_pointer     (bch_user_pointer),
        .slot_status          (slot_status),
        .tx_enable            (tx_enable)
    );

    ping_engine i_ping_engine (
        .clk           (clk),
        .reset_n       (reset_n),
        .gps_time      (gps_time),
        .tx_enable     (tx_enable),
        .start_ping    (start_ping),
        .open_loop     (open_loop),
        .recv_ping     (recv_ping),
        .recv_ack_ping (recv_ack_ping),
        .recv_fields   (recv_fields),
        .sendbuf       (sendbuf),
        .ping_report   (ping_report),
        .send_ping     (send_ping)
    );

    tx_launcher i_tx_launcher (
        .clk          (clk),
        .reset_n      (reset_n),
        .send_ping    (send_ping),
        .test_sendpkt (test_sendpkt),
        .tx_enable    (tx_enable),
        .tx_ack       (tx_ack),
        .tx_req       (tx_req)
    );

endmodule

`default_nettype wire

// ==== testbench/tb_tdma_control.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "tdma_defines.svh"

module tb_tdma_control;

    logic                   clk;
    logic                   reset_n;
    logic                   gps_timepulse_1;
    logic                   gps_timepulse_2;
    tdma_pkg::utc_sec_t     utc_sec_in;
    logic                   tdma_function_enable;
    tdma_pkg::slot_index_t  bch_user_pointer;
    logic                   start_ping;
    logic                   open_loop;
    logic                   recv_ping;
    logic                   recv_ack_ping;
    tdma_pkg::ping_fields_t recv_fields;
    logic                   test_sendpkt;
    logic                   tx_ack;
    tdma_pkg::gps_time_t    gps_time;
    tdma_pkg::slot_status_t slot_status;
    logic                   tx_enable;
    tdma_pkg::sendbuf_wr_t  sendbuf;
    tdma_pkg::ping_report_t ping_report;
    logic                   tx_req;

    int          errors;
    int          checks;
    int          timeouts;
    int          proto_errors;
    int          hs_count;
    logic [31:0] rng;
    logic [2:0]  ack_delays [64];

    // reference GPS time kept by the testbench
    logic [31:0] model_sec;
    int          model_p1;
    int          p2_since_p1;

    // every send-buffer write seen so far
    logic [8:0]  wr_addr_q [$];
    logic [31:0] wr_data_q [$];

    logic prev_req;
    logic prev_ack;
    logic prev_en;

    tdma_control i_dut (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [31:0] next_rand();
        rng = xorshift32(rng);
        return rng;
    endfunction

    task automatic step(input int n);
        repeat (n) begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("** Error at %t: %s expected 0x%0h, got 0x%0h", $time, name, exp, got);
        end
    endtask

    task automatic pulse_second(input logic [31:0] sec);
        utc_sec_in      = sec;
        gps_timepulse_1 = 1'b1;
        step(3);
        gps_timepulse_1 = 1'b0;
        step(3);
        model_sec   = sec;
        model_p1++;
        p2_since_p1 = 0;
    endtask

    task automatic pulse_fine();
        gps_timepulse_2 = 1'b1;
        step(3);
        gps_timepulse_2 = 1'b0;
        step(3);
        p2_since_p1++;
    endtask

    // waits for n more completed handshakes and makes sure no extra one follows
    task automatic expect_handshakes(input int base, input int n);
        int guard;
        guard = 0;
        while (hs_count < base + n && guard < 400) begin
            step(1);
            guard++;
        end
        if (hs_count < base + n) begin
            timeouts++;
            $display("timeout at %t: expected %0d tx handshakes, only %0d completed",
                     $time, n, hs_count - base);
        end
        step(20);
        check("handshake count", hs_count - base, n);
        check("tx_req", 32'(tx_req), 0);
    endtask

    task automatic check_payload(input int base, input logic [31:0] kind, seq, sec, cnt2);
        logic [31:0] exp_words [`TDMA_PKT_WORDS];
        exp_words = '{kind, seq, sec, cnt2};
        check("send-buffer write count", wr_data_q.size() - base, `TDMA_PKT_WORDS);
        if (wr_data_q.size() - base == `TDMA_PKT_WORDS) begin
            for (int i = 0; i < `TDMA_PKT_WORDS; i++) begin
                check("sendbuf.addr", 32'(wr_addr_q[base + i]), i);
                check("sendbuf.data", wr_data_q[base + i], exp_words[i]);
            end
        end
    endtask

    task automatic send_ack(input logic [31:0] seq, sec, cnt2, exp_delta);
        recv_fields.seq      = seq;
        recv_fields.sec      = sec;
        recv_fields.counter2 = cnt2;
        recv_ack_ping = 1'b1;
        step(1);
        recv_ack_ping = 1'b0;
        step(1);
        check("ping_report.res_seq", ping_report.res_seq, seq);
        check("ping_report.res_delta_t", ping_report.res_delta_t, exp_delta);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // transmitter model with random ack delays of 0 to 7 cycles
    ////////////////////////////////////////////////////////////////////////////
    initial begin : transmitter
        int delay;
        int pick;
        tx_ack = 1'b0;
        delay  = 0;
        pick   = 0;
        forever begin
            @(posedge clk);
            #1;
            if (tx_req != tx_ack) begin
                if (delay == 0) begin
                    tx_ack = tx_req;
                    pick   = (pick + 1) % 64;
                    delay  = int'(ack_delays[pick]);
                end else begin
                    delay--;
                end
            end
        end
    end

    // send-buffer capture and four-phase order sampled mid-cycle
    always @(negedge clk) begin
        if (!reset_n) begin
            prev_req = 1'b0;
            prev_ack = 1'b0;
            prev_en  = 1'b1;
        end else begin
            if (sendbuf.we) begin
                wr_addr_q.push_back(sendbuf.addr);
                wr_data_q.push_back(sendbuf.data);
            end
            assert (tx_req || !prev_req || prev_ack) else begin
                proto_errors++;
                $display("%t: tx_req fell before tx_ack rose", $time);
            end
            assert (!tx_req || prev_req || (!prev_ack && prev_en)) else begin
                proto_errors++;
                $display("%t: tx_req rose while tx_ack was high or the gate was closed", $time);
            end
            if (prev_ack && !tx_ack) begin
                hs_count++;
            end
            prev_req = tx_req;
            prev_ack = tx_ack;
            prev_en  = tx_enable;
        end
    end

    initial begin : watchdog
        #1_000_000;
        $display("simulation ran past its time limit");
        $display("RESULT: FAIL");
        $finish;
    end

    ////////////////////////////////////////////////////////////////////////////
    // main sequence
    ////////////////////////////////////////////////////////////////////////////
    initial begin : stimulus
        int          base;
        int          hs_base;
        logic [31:0] seq;
        logic [31:0] c2;
        $timeformat(-9, 0, " ns", 0);
        reset_n              = 1'b0;
        gps_timepulse_1      = 1'b0;
        gps_timepulse_2      = 1'b0;
        utc_sec_in           = '0;
        tdma_function_enable = 1'b0;
        bch_user_pointer     = `TDMA_NO_SLOT;
        start_ping           = 1'b0;
        open_loop            = 1'b0;
        recv_ping            = 1'b0;
        recv_ack_ping        = 1'b0;
        recv_fields          = '0;
        test_sendpkt         = 1'b0;
        rng                  = 32'ha1e2_a754;
        foreach (ack_delays[i]) begin
            ack_delays[i] = 3'(next_rand());
        end
        step(10);
        reset_n = 1'b1;
        step(1);
        check("tx_req", 32'(tx_req), 0);
        check("sendbuf.we", 32'(sendbuf.we), 0);
        check("send_ping", 32'(i_dut.send_ping), 0);
        check("ping_report.res_seq", ping_report.res_seq, 0);
        check("ping_report.res_delta_t", ping_report.res_delta_t, 0);
        check("tx_enable", 32'(tx_enable), 1);

        // GPS counters
        for (int n = 0; n < 3; n++) begin
            pulse_second(next_rand());
        end
        check("gps_time.pulse1_count", gps_time.pulse1_count, model_p1);
        check("gps_time.utc_sec", gps_time.utc_sec, model_sec);
        repeat (5) pulse_fine();
        check("gps_time.pulse2_count", gps_time.pulse2_count, p2_since_p1 - 1);

        // slot tick and index across two and a half slots
        pulse_second(next_rand());
        for (int k = 1; k <= 2500; k++) begin
            pulse_fine();
            check("slot_status.slot_tick", 32'(slot_status.slot_tick),
                  (k - 1) % `TDMA_SLOT_PULSES);
            check("slot_status.slot_index", 32'(slot_status.slot_index),
                  (k - 1) / `TDMA_SLOT_PULSES);
        end
        pulse_second(next_rand());
        pulse_fine();
        check("slot_status.slot_tick", 32'(slot_status.slot_tick), 0);
        check("slot_status.slot_index", 32'(slot_status.slot_index), 0);
        check("gps_time.pulse2_count", gps_time.pulse2_count, 0);

        // transmit gate while slot index is 0
        bch_user_pointer = 16'd7;
        step(2);
        check("tx_enable", 32'(tx_enable), 1);
        tdma_function_enable = 1'b1;
        bch_user_pointer     = `TDMA_NO_SLOT;
        step(2);
        check("tx_enable", 32'(tx_enable), 0);
        bch_user_pointer = 16'd0;
        step(2);
        check("tx_enable", 32'(tx_enable), 1);
        bch_user_pointer = 16'(1 + next_rand() % 99);
        step(2);
        check("tx_enable", 32'(tx_enable), 0);

        // ping start with the gate open
        tdma_function_enable = 1'b0;
        repeat (3) pulse_fine();
        for (int r = 0; r < 4; r++) begin
            base    = wr_data_q.size();
            hs_base = hs_count;
            start_ping = 1'b1;
            step(1);
            start_ping = 1'b0;
            expect_handshakes(hs_base, 1);
            check_payload(base, 32'(tdma_pkg::KIND_PING), 32'd1, model_sec, p2_since_p1 - 1);
        end

        // ping start held back by a closed gate
        tdma_function_enable = 1'b1;
        bch_user_pointer     = `TDMA_NO_SLOT;
        step(2);
        base    = wr_data_q.size();
        hs_base = hs_count;
        start_ping = 1'b1;
        step(1);
        start_ping = 1'b0;
        step(20);
        check("tx_req", 32'(tx_req), 0);
        check("send-buffer write count", wr_data_q.size() - base, 0);
        bch_user_pointer = 16'd0;
        expect_handshakes(hs_base, 1);
        check_payload(base, 32'(tdma_pkg::KIND_PING), 32'd1, model_sec, p2_since_p1 - 1);

        // ping reply echoes random fields
        recv_fields.seq      = next_rand();
        recv_fields.sec      = next_rand();
        recv_fields.counter2 = next_rand() % 1000000;
        base    = wr_data_q.size();
        hs_base = hs_count;
        recv_ping = 1'b1;
        step(1);
        recv_ping = 1'b0;
        expect_handshakes(hs_base, 1);
        check_payload(base, 32'(tdma_pkg::KIND_ACK_PING), recv_fields.seq,
                      recv_fields.sec, recv_fields.counter2);

        // two test sends pile up behind a closed gate
        bch_user_pointer = `TDMA_NO_SLOT;
        step(2);
        hs_base = hs_count;
        test_sendpkt = 1'b1;
        step(1);
        test_sendpkt = 1'b0;
        step(2);
        test_sendpkt = 1'b1;
        step(1);
        test_sendpkt = 1'b0;
        step(20);
        check("tx_req", 32'(tx_req), 0);
        check("handshake count", hs_count - hs_base, 0);
        bch_user_pointer = 16'd0;
        expect_handshakes(hs_base, 2);

        // acknowledgments with the fine pulses held still from here on
        base    = wr_data_q.size();
        hs_base = hs_count;
        c2 = next_rand() % p2_since_p1;
        send_ack(next_rand(), model_sec, c2, (p2_since_p1 - 1) - c2);
        c2 = next_rand() % 1000000;
        send_ack(next_rand(), model_sec - 32'd1, c2,
                 (p2_since_p1 - 1) + `TDMA_PULSE2_WRAP - c2);
        step(10);
        check("send-buffer write count", wr_data_q.size() - base, 0);
        check("handshake count", hs_count - hs_base, 0);

        // open loop sends the next ping straight away
        open_loop = 1'b1;
        seq = next_rand();
        c2  = next_rand() % p2_since_p1;
        send_ack(seq, model_sec, c2, (p2_since_p1 - 1) - c2);
        expect_handshakes(hs_base, 1);
        check_payload(base, 32'(tdma_pkg::KIND_PING), seq + 32'd1, model_sec, p2_since_p1 - 1);
        open_loop = 1'b0;

        step(5);
        $display("checks %0d, errors %0d, handshake errors %0d, timeouts %0d",
                 checks, errors, proto_errors, timeouts);
        if (errors == 0 && proto_errors == 0 && timeouts == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== tdma_control.f ====
+incdir+logic
logic/tdma_pkg.sv
logic/gps_pulse_sync.sv
logic/gps_time_base.sv
logic/slot_scheduler.sv
logic/ping_engine.sv
logic/tx_launcher.sv
logic/tdma_control.sv
testbench/tb_tdma_control.sv

// ==== Makefile ====
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert -j 0
TOP       ?= tb_tdma_control
FILELIST  ?= tdma_control.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "RESULT: PASS" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
